/* bench/cache_testdata.txt */
// phase port(0 instr, 1 data) op(0 load, 1 store) addr wdata exp_data exp_hit
// addr and data are hex; phase 0 finishes before phase 1 starts
0 1 1 00000010 a5a50001 a5a50001 0
0 1 1 00000020 a5a50002 a5a50002 0
0 1 1 00000110 a5a50003 a5a50003 0
0 1 0 00000110 00000000 a5a50003 1
0 1 0 00000010 00000000 a5a50001 0
0 1 0 00000110 00000000 a5a50003 0
0 1 1 00000110 a5a50004 a5a50004 1
0 1 0 00000040 00000000 00000000 0
0 1 0 00000040 00000000 00000000 1
0 1 1 00000300 a5a50005 a5a50005 0
1 0 0 00000010 00000000 a5a50001 0
1 0 0 00000020 00000000 a5a50002 0
1 0 0 00000020 00000000 a5a50002 1
1 0 0 00000110 00000000 a5a50004 0
1 0 0 00000010 00000000 a5a50001 0
1 0 0 00000300 00000000 a5a50005 0
1 0 0 00000300 00000000 a5a50005 1
1 1 1 00000080 11112222 11112222 0
1 1 0 00000080 00000000 11112222 1
1 1 0 00000180 00000000 00000000 0
1 1 0 00000080 00000000 11112222 0
1 1 0 00000040 00000000 00000000 1
1 1 1 00000084 33334444 33334444 0
1 1 0 00000084 00000000 33334444 1

/* tb.f */
+incdir+source
source/cache_pkg.sv
source/bram.sv
source/direct_map.sv
source/cache_port.sv
source/mem_arbiter.sv
source/backing_memory.sv
source/cache_top.sv
bench/cache_checker.sv
bench/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top \
  -o tb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
  exit 1
fi
exit 0

/* bench/tb_top.sv */
`include "cache_defs.svh"

module tb_top;
  typedef struct packed {
    logic                 phase;
    cache_pkg::port_id_t  port;
    cache_pkg::cache_op_t op;
    logic [31:0]          addr;
    logic [31:0]          wdata;
    logic [31:0]          exp_data;
    logic                 exp_hit;
  } test_op_t;

  logic                  clk;
  logic                  reset;
  logic [1:0]            req_valid;
  logic [1:0]            ready;
  logic [1:0]            rsp_valid;
  cache_pkg::cache_req_t req [2];
  cache_pkg::cache_rsp_t rsp [2];
  test_op_t              ops [$];
  longint                time_limit;
  logic                  limit_set;
  int                    checks;
  int                    errors;

  // Index 0 is the instruction port, index 1 the data port
  cache_top i_dut (
    .clk, .reset,
    .instr_req_valid(req_valid[0]), .instr_req(req[0]), .instr_ready(ready[0]),
    .instr_rsp_valid(rsp_valid[0]), .instr_rsp(rsp[0]),
    .data_req_valid(req_valid[1]), .data_req(req[1]), .data_ready(ready[1]),
    .data_rsp_valid(rsp_valid[1]), .data_rsp(rsp[1])
  );

  cache_checker i_checker (
    .clk,
    .instr_req_valid(req_valid[0]), .instr_ready(ready[0]),
    .instr_rsp_valid(rsp_valid[0]), .instr_rsp(rsp[0]),
    .data_req_valid(req_valid[1]), .data_ready(ready[1]),
    .data_rsp_valid(rsp_valid[1]), .data_rsp(rsp[1]),
    .checks, .errors
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ==============================
  // Test data
  // ==============================
  function automatic bit load_tests();
    int          fd;
    int          rc;
    int          ph, pt, op, eh;
    logic [31:0] addr, wd, ed;
    string       line;
    bit          ok;
    ok = 1'b1;
    fd = $fopen("bench/cache_testdata.txt", "r");
    if (fd == 0) begin
      return 1'b0;
    end
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      if (rc == 0 || line.len() < 8 || line.getc(0) == "/") begin
        continue;
      end
      rc = $sscanf(line, "%d %d %d %h %h %h %d", ph, pt, op, addr, wd, ed, eh);
      if (rc != 7) begin
        $display("Malformed test data line: %s", line);
        ok = 1'b0;
      end else begin
        ops.push_back('{phase: ph[0], port: cache_pkg::port_id_t'(pt[0]),
                        op: cache_pkg::cache_op_t'(op[0]), addr: addr, wdata: wd,
                        exp_data: ed, exp_hit: eh[0]});
      end
    end
    $fclose(fd);
    return ok && ops.size() > 0;
  endfunction

  // ==============================
  // Drivers
  // ==============================
  task automatic issue(input test_op_t t);
    int p;
    p = int'(t.port);
    while (!ready[p]) @(negedge clk);
    req[p] = '{op: t.op, addr: t.addr, wdata: t.wdata};
    req_valid[p] = 1'b1;
    @(negedge clk);
    req_valid[p] = 1'b0;
  endtask

  task automatic run_port(input int p);
    for (int i = 0; i < ops.size(); i++) begin
      if (ops[i].phase == 1'b1 && int'(ops[i].port) == p) begin
        issue(ops[i]);
      end
    end
  endtask

  // Ready comes back with the last response; one more edge lets the checker see it
  task automatic wait_idle();
    while (ready != 2'b11) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic run_all();
    int missing;
    for (int i = 0; i < ops.size(); i++) begin
      i_checker.add_expect(ops[i].port, ops[i].addr, ops[i].exp_data, ops[i].exp_hit);
    end
    repeat (8) @(negedge clk);
    reset = 1'b0;
    wait_idle();
    for (int i = 0; i < ops.size(); i++) begin
      if (ops[i].phase == 1'b0) begin
        issue(ops[i]);
      end
    end
    wait_idle();
    fork
      run_port(0);
      run_port(1);
    join
    wait_idle();
    missing = i_checker.pending();
    if (missing != 0) begin
      $display("%0d expected responses never arrived", missing);
    end
    $display("Checks: %0d  errors: %0d  missing responses: %0d", checks, errors, missing);
    if (errors == 0 && missing == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  initial begin
    reset = 1'b1;
    req_valid = '0;
    req[0] = '0;
    req[1] = '0;
    limit_set = 1'b0;
    if (!load_tests()) begin
      $display("Could not read the operations in bench/cache_testdata.txt");
      $display("FAIL: see errors above");
      $finish;
    end else begin
      time_limit = longint'(ops.size()) * (`MEM_LATENCY + 8) * 8 * 2
                   + `CACHE_LINES * 8 + 8 * 8;
      limit_set = 1'b1;
      run_all();
    end
  end

  // Watchdog
  initial begin
    wait (limit_set);
    #(time_limit);
    $display("Timeout: the run did not finish within %0d time units", time_limit);
    $display("FAIL: see errors above");
    $finish;
  end
endmodule

/* bench/cache_checker.sv */
module cache_checker (
  input  logic                  clk,
  input  logic                  instr_req_valid,
  input  logic                  instr_ready,
  input  logic                  instr_rsp_valid,
  input  cache_pkg::cache_rsp_t instr_rsp,
  input  logic                  data_req_valid,
  input  logic                  data_ready,
  input  logic                  data_rsp_valid,
  input  cache_pkg::cache_rsp_t data_rsp,
  output int                    checks,
  output int                    errors
);
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic        hit;
  } expect_t;

  expect_t instr_q [$];
  expect_t data_q [$];
  bit [1:0] accepted;
  int      check_count = 0;
  int      error_count = 0;

  assign checks = check_count;
  assign errors = error_count;

  task automatic add_expect(input cache_pkg::port_id_t port, input logic [31:0] addr,
                            input logic [31:0] data, input logic hit);
    if (port == cache_pkg::PORT_INSTR) begin
      instr_q.push_back('{addr: addr, data: data, hit: hit});
    end else begin
      data_q.push_back('{addr: addr, data: data, hit: hit});
    end
  endtask

  function automatic int pending();
    return instr_q.size() + data_q.size();
  endfunction

  task automatic compare(input string name, input cache_pkg::cache_rsp_t got,
                         input expect_t exp);
    check_count++;
    if (got.data !== exp.data) begin
      error_count++;
      $display("ERR %s_rsp.data: got %h expected %h at addr %h", name, got.data, exp.data,
               exp.addr);
    end
    if (got.hit !== exp.hit) begin
      error_count++;
      $display("ERR %s_rsp.hit: got %h expected %h at addr %h", name, got.hit, exp.hit,
               exp.addr);
    end
  endtask

  // Ready drops after an accepted request and is back with the response
  task automatic check_ready(input string name, input logic ready, input logic rsp_valid,
                             input logic was_accepted);
    if (was_accepted && ready !== 1'b0) begin
      error_count++;
      $display("ERR %s_ready: got %h expected 0 after an accepted request", name, ready);
    end
    if (rsp_valid === 1'b1 && ready !== 1'b1) begin
      error_count++;
      $display("ERR %s_ready: got %h expected 1 with the response", name, ready);
    end
  endtask

  // Requests taken at this edge
  always @(posedge clk) begin
    accepted[0] <= (instr_req_valid === 1'b1) && (instr_ready === 1'b1);
    accepted[1] <= (data_req_valid === 1'b1) && (data_ready === 1'b1);
  end

  // Responses are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    check_ready("instr", instr_ready, instr_rsp_valid, accepted[0]);
    check_ready("data", data_ready, data_rsp_valid, accepted[1]);
    if (instr_rsp_valid === 1'b1) begin
      if (instr_q.size() == 0) begin
        error_count++;
        $display("Response on the instr port while no response was expected");
      end else begin
        compare("instr", instr_rsp, instr_q.pop_front());
      end
    end
    if (data_rsp_valid === 1'b1) begin
      if (data_q.size() == 0) begin
        error_count++;
        $display("Response on the data port while no response was expected");
      end else begin
        compare("data", data_rsp, data_q.pop_front());
      end
    end
  end
endmodule

/* source/cache_top.sv */
`default_nettype none

module cache_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  instr_req_valid,
  input  cache_pkg::cache_req_t instr_req,
  output logic                  instr_ready,
  output logic                  instr_rsp_valid,
  output cache_pkg::cache_rsp_t instr_rsp,
  input  logic                  data_req_valid,
  input  cache_pkg::cache_req_t data_req,
  output logic                  data_ready,
  output logic                  data_rsp_valid,
  output cache_pkg::cache_rsp_t data_rsp
);
  cache_pkg::mem_req_t instr_mem_req, data_mem_req, mem_req;
  cache_pkg::mem_rsp_t mem_rsp;
  logic                instr_mem_req_valid, data_mem_req_valid;
  logic                instr_grant, data_grant;
  logic                mem_req_valid, mem_rsp_valid, mem_wr_ack;

  // ==============================
  // Cache ports
  // ==============================
  cache_port #(.port_id(cache_pkg::PORT_INSTR)) i_instr_port (
    .clk, .reset,
    .req_valid(instr_req_valid), .req(instr_req), .ready(instr_ready),
    .rsp_valid(instr_rsp_valid), .rsp(instr_rsp),
    .mem_req_valid(instr_mem_req_valid), .mem_req(instr_mem_req), .grant(instr_grant),
    .mem_rsp_valid, .mem_rsp, .mem_wr_ack
  );

  cache_port #(.port_id(cache_pkg::PORT_DATA)) i_data_port (
    .clk, .reset,
    .req_valid(data_req_valid), .req(data_req), .ready(data_ready),
    .rsp_valid(data_rsp_valid), .rsp(data_rsp),
    .mem_req_valid(data_mem_req_valid), .mem_req(data_mem_req), .grant(data_grant),
    .mem_rsp_valid, .mem_rsp, .mem_wr_ack
  );

  // ==============================
  // Shared memory
  // ==============================
  mem_arbiter i_arbiter (
    .clk, .reset,
    .instr_req_valid(instr_mem_req_valid), .instr_req(instr_mem_req),
    .data_req_valid(data_mem_req_valid), .data_req(data_mem_req),
    .instr_grant, .data_grant,
    .mem_req_valid, .mem_req
  );

  backing_memory i_memory (
    .clk, .reset,
    .mem_req_valid, .mem_req,
    .mem_rsp_valid, .mem_rsp, .mem_wr_ack
  );
endmodule

`default_nettype wire

/* source/backing_memory.sv */
`default_nettype none
`include "cache_defs.svh"

module backing_memory (
  input  logic                clk,
  input  logic                reset,
  input  logic                mem_req_valid,
  input  cache_pkg::mem_req_t mem_req,
  output logic                mem_rsp_valid,
  output cache_pkg::mem_rsp_t mem_rsp,
  output logic                mem_wr_ack
);
  logic [31:0]                mem [`MEM_WORDS];
  logic [`MEM_LATENCY-1:0]    pipe_valid;
  cache_pkg::mem_rsp_t        pipe_rsp [`MEM_LATENCY];
  logic                       rd, wr, read_busy;

  assign rd = mem_req_valid && (mem_req.op == cache_pkg::OP_LOAD);
  assign wr = mem_req_valid && (mem_req.op == cache_pkg::OP_STORE);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
      pipe_valid <= '0;
      mem_wr_ack <= 1'b0;
    end else begin
      for (int i = `MEM_LATENCY - 1; i > 0; i--) begin
        pipe_valid[i] <= pipe_valid[i-1];
      end
      pipe_valid[0] <= rd;
      mem_wr_ack    <= wr;
      if (wr) begin
        mem[mem_req.addr] <= mem_req.wdata;
      end
    end
  end

  // Read data and port id ride along with the valid bits
  always_ff @(posedge clk) begin
    pipe_rsp[0].data <= mem[mem_req.addr];
    pipe_rsp[0].port <= mem_req.port;
    for (int i = 1; i < `MEM_LATENCY; i++) begin
      pipe_rsp[i] <= pipe_rsp[i-1];
    end
  end

  assign mem_rsp_valid = pipe_valid[`MEM_LATENCY-1];
  assign mem_rsp       = pipe_rsp[`MEM_LATENCY-1];

  // Set when the requesting port already has a read in the pipeline
  always_comb begin
    read_busy = 1'b0;
    for (int i = 0; i < `MEM_LATENCY; i++) begin
      if (pipe_valid[i] && pipe_rsp[i].port == mem_req.port) begin
        read_busy = 1'b1;
      end
    end
  end

  a_one_read_per_port: assert property (@(posedge clk) disable iff (reset)
    rd |-> !read_busy);
endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
`default_nettype none

module mem_arbiter (
  input  logic                clk,
  input  logic                reset,
  input  logic                instr_req_valid,
  input  cache_pkg::mem_req_t instr_req,
  input  logic                data_req_valid,
  input  cache_pkg::mem_req_t data_req,
  output logic                instr_grant,
  output logic                data_grant,
  output logic                mem_req_valid,
  output cache_pkg::mem_req_t mem_req
);
  cache_pkg::port_id_t last_grant;

  // On a tie the port not served last wins
  always_comb begin
    instr_grant = 1'b0;
    data_grant  = 1'b0;
    if (instr_req_valid && data_req_valid) begin
      if (last_grant == cache_pkg::PORT_INSTR) begin
        data_grant = 1'b1;
      end else begin
        instr_grant = 1'b1;
      end
    end else begin
      instr_grant = instr_req_valid;
      data_grant  = data_req_valid;
    end
  end

  assign mem_req_valid = instr_grant | data_grant;
  assign mem_req       = data_grant ? data_req : instr_req;

  always_ff @(posedge clk) begin
    if (reset) begin
      last_grant <= cache_pkg::PORT_DATA;
    end else if (instr_grant) begin
      last_grant <= cache_pkg::PORT_INSTR;
    end else if (data_grant) begin
      last_grant <= cache_pkg::PORT_DATA;
    end
  end

  // A port that loses a tie is served in the next cycle
  a_instr_next: assert property (@(posedge clk) disable iff (reset)
    instr_req_valid && !instr_grant |=> instr_grant);

  a_data_next: assert property (@(posedge clk) disable iff (reset)
    data_req_valid && !data_grant |=> data_grant);
endmodule

`default_nettype wire

/* source/cache_port.sv */
`default_nettype none
`include "cache_defs.svh"

module cache_port #(
  parameter cache_pkg::port_id_t port_id = cache_pkg::PORT_INSTR
)(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_valid,
  input  cache_pkg::cache_req_t req,
  output logic                  ready,
  output logic                  rsp_valid,
  output cache_pkg::cache_rsp_t rsp,
  output logic                  mem_req_valid,
  output cache_pkg::mem_req_t   mem_req,
  input  logic                  grant,
  input  logic                  mem_rsp_valid,
  input  cache_pkg::mem_rsp_t   mem_rsp,
  input  logic                  mem_wr_ack
);
  localparam MEM_AW = $clog2(`MEM_WORDS);

  cache_pkg::fill_state_t   state;
  cache_pkg::cache_req_t    req_q;
  cache_pkg::cache_rsp_t    rsp_q;
  logic                     accepting, accept, sweeping, is_store, rsp_mine;
  logic                     line_hit, write_valid;
  logic [31:0]              line_data, write_data;
  logic [`CACHE_ADDR_W-1:0] lookup_addr;

  assign accepting = (state == cache_pkg::S_IDLE || state == cache_pkg::S_RESP) && !sweeping;
  assign accept    = req_valid && accepting;
  assign is_store  = (req_q.op == cache_pkg::OP_STORE);
  assign rsp_mine  = mem_rsp_valid && (mem_rsp.port == port_id);

  assign ready     = accepting;
  assign rsp_valid = (state == cache_pkg::S_RESP);
  assign rsp       = rsp_q;

  // RAM read starts in the accept cycle
  assign lookup_addr = accepting ? req.addr : req_q.addr;
  assign write_valid = (state == cache_pkg::S_LOOKUP && is_store) || state == cache_pkg::S_FILL;
  assign write_data  = (state == cache_pkg::S_FILL) ? rsp_q.data : req_q.wdata;

  direct_map #(.LINE_SIZE(4), .CACHE_SIZE(`CACHE_LINES * 4)) i_cache (
    .clk,
    .reset,
    .req_addr(lookup_addr),
    .hit(line_hit),
    .data(line_data),
    .write_addr(req_q.addr),
    .write_data,
    .write_valid,
    .sweeping
  );

  assign mem_req_valid = (state == cache_pkg::S_MEM_REQ);
  assign mem_req.op    = req_q.op;
  assign mem_req.addr  = req_q.addr[2 +: MEM_AW];
  assign mem_req.wdata = req_q.wdata;
  assign mem_req.port  = port_id;

  // ==============================
  // Control FSM
  // ==============================
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_pkg::S_IDLE;
    end else begin
      case (state)
        cache_pkg::S_IDLE, cache_pkg::S_RESP:
          state <= accept ? cache_pkg::S_LOOKUP : cache_pkg::S_IDLE;
        cache_pkg::S_LOOKUP:
          state <= (is_store || !line_hit) ? cache_pkg::S_MEM_REQ : cache_pkg::S_RESP;
        cache_pkg::S_MEM_REQ:
          if (grant) begin
            state <= cache_pkg::S_MEM_WAIT;
          end
        cache_pkg::S_MEM_WAIT:
          if (is_store && mem_wr_ack) begin
            state <= cache_pkg::S_RESP;
          end else if (!is_store && rsp_mine) begin
            state <= cache_pkg::S_FILL;
          end
        cache_pkg::S_FILL:
          state <= cache_pkg::S_RESP;
        default:
          state <= cache_pkg::S_IDLE;
      endcase
    end
  end

  // Fill data waits in rsp_q until the line is written
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req;
    end
    if (state == cache_pkg::S_LOOKUP) begin
      rsp_q.data <= is_store ? req_q.wdata : line_data;
      rsp_q.hit  <= line_hit;
    end else if (state == cache_pkg::S_MEM_WAIT && !is_store && rsp_mine) begin
      rsp_q.data <= mem_rsp.data;
      rsp_q.hit  <= 1'b0;
    end
  end

  a_req_when_ready: assert property (@(posedge clk) disable iff (reset)
    req_valid |-> ready);

  // Memory answers this port only while it waits for a read
  a_rsp_when_waiting: assert property (@(posedge clk) disable iff (reset)
    rsp_mine |-> state == cache_pkg::S_MEM_WAIT && !is_store);
endmodule

`default_nettype wire

/* source/direct_map.sv */
`default_nettype none
`include "cache_defs.svh"

module direct_map #(
  parameter LINE_SIZE  = 4,
  parameter CACHE_SIZE = 256
)(
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`CACHE_ADDR_W-1:0] req_addr,
  output logic                     hit,
  output logic [LINE_SIZE*8-1:0]   data,
  input  logic [`CACHE_ADDR_W-1:0] write_addr,
  input  logic [LINE_SIZE*8-1:0]   write_data,
  input  logic                     write_valid,
  output logic                     sweeping
);
  localparam LINE_NUM = CACHE_SIZE / LINE_SIZE;
  localparam OFFSET_W = $clog2(LINE_SIZE);
  localparam INDEX_W  = $clog2(LINE_NUM);
  localparam TAG_W    = `CACHE_ADDR_W - INDEX_W - OFFSET_W;

  logic [INDEX_W-1:0] req_index, write_index, sweep_index, ram_addr;
  logic [TAG_W-1:0]   req_tag, write_tag;
  logic [TAG_W:0]     tag_in, tag_out;

  assign req_index   = req_addr[OFFSET_W +: INDEX_W];
  assign req_tag     = req_addr[OFFSET_W + INDEX_W +: TAG_W];
  assign write_index = write_addr[OFFSET_W +: INDEX_W];
  assign write_tag   = write_addr[OFFSET_W + INDEX_W +: TAG_W];

  // Invalidate every line once after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      sweeping    <= 1'b1;
      sweep_index <= '0;
    end else if (sweeping) begin
      sweep_index <= sweep_index + 1'b1;
      if (sweep_index == INDEX_W'(LINE_NUM - 1)) begin
        sweeping <= 1'b0;
      end
    end
  end

  assign ram_addr = sweeping ? sweep_index : (write_valid ? write_index : req_index);
  assign tag_in   = sweeping ? '0 : {1'b1, write_tag};

  bram #(.DATA_WIDTH(LINE_SIZE * 8), .DEPTH(LINE_NUM)) i_data_ram (
    .clk,
    .addr(ram_addr),
    .wen(write_valid),
    .din(write_data),
    .dout(data)
  );

  // Top bit is the valid flag
  bram #(.DATA_WIDTH(TAG_W + 1), .DEPTH(LINE_NUM)) i_tag_ram (
    .clk,
    .addr(ram_addr),
    .wen(sweeping | write_valid),
    .din(tag_in),
    .dout(tag_out)
  );

  assign hit = tag_out[TAG_W] & (tag_out[TAG_W-1:0] == req_tag);

  a_no_write_in_sweep: assert property (@(posedge clk) disable iff (reset)
    sweeping |-> !write_valid);
endmodule

`default_nettype wire

/* source/bram.sv */
`default_nettype none

module bram #(
  parameter DATA_WIDTH = 32,
  parameter DEPTH      = 64
)(
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic                     wen,
  input  logic [DATA_WIDTH-1:0]    din,
  output logic [DATA_WIDTH-1:0]    dout
);
  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // Read returns the old contents on a write cycle
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[addr] <= din;
    end
    dout <= mem[addr];
  end
endmodule

`default_nettype wire

/* source/cache_pkg.sv */
`include "cache_defs.svh"

package cache_pkg;

  typedef enum logic {PORT_INSTR, PORT_DATA} port_id_t;

  typedef enum logic {OP_LOAD, OP_STORE} cache_op_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_MEM_REQ,
    S_MEM_WAIT,
    S_FILL,
    S_RESP
  } fill_state_t;

  // ==============================
  // Core side
  // ==============================
  typedef struct packed {
    cache_op_t                op;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [31:0]              wdata;
  } cache_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic        hit;
  } cache_rsp_t;

  // ==============================
  // Memory side, word addressed
  // ==============================
  typedef struct packed {
    cache_op_t                      op;
    logic [$clog2(`MEM_WORDS)-1:0] addr;
    logic [31:0]                    wdata;
    port_id_t                       port;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] data;
    port_id_t    port;
  } mem_rsp_t;

endpackage

/* source/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Byte address width of both cache ports
`define CACHE_ADDR_W 32

// Lines per cache, one 32-bit word each
`define CACHE_LINES 64

// Backing memory size in 32-bit words
`define MEM_WORDS 1024

// Read latency of the backing memory in cycles
`define MEM_LATENCY 3

`endif
